/* Makefile */
# Verilator build and run of the four-lane receive reset sequencer testbench

VERILATOR   ?= verilator
TOP         ?= tb_rx_rst
FLIST       ?= flist.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing --assert -j 0
ERROR_LIMIT ?= 100
PASS_MSG    ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS ERROR_LIMIT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* design/rx_lane_rst_fsm.sv */
//////////////////////////////
// Receive reset FSM for one lane
// Orders power-up, PMA and PCS reset release and done
//////////////////////////////
module rx_lane_rst_fsm (
    input  logic clk,
    input  logic i_lane_rstn,
    input  logic i_pll_lock,
    input  logic i_sigdet,
    input  logic i_cdr_align,
    input  logic i_word_align,
    output logic o_lane_pd,
    output logic o_lane_rst,
    output logic o_rx_pma_rst,
    output logic o_pcs_rx_rst,
    output logic o_rxlane_done
);
    import rx_rst_pkg::*;

    localparam int WAIT_W = 4;
    localparam logic [WAIT_W-1:0] PD_WAIT_LAST  = WAIT_W'(PD_WAIT_CYCLES - 1);
    localparam logic [WAIT_W-1:0] PCS_WAIT_LAST = WAIT_W'(PCS_RST_WAIT_CYCLES - 1);

    rx_fsm_state_t     state_q;
    rx_fsm_state_t     state_d;
    logic [WAIT_W-1:0] wait_cnt;                              // Cycles spent in the current wait state
    logic              link_ok;                               // Signal present and CDR locked

    assign link_ok = i_sigdet & i_cdr_align;

    //////////////////////////////
    // Next state
    //////////////////////////////
    always_comb begin
        state_d = state_q;
        if (!i_pll_lock) begin
            state_d = ST_LANE_OFF;                            // Lock loss restarts from power-down
        end else begin
            unique case (state_q)
                ST_LANE_OFF: begin
                    state_d = ST_PD_WAIT;
                end
                ST_PD_WAIT: begin
                    if (wait_cnt == PD_WAIT_LAST) begin
                        state_d = ST_WAIT_SIGDET;
                    end
                end
                ST_WAIT_SIGDET: begin
                    if (i_sigdet) begin
                        state_d = ST_WAIT_CDR;
                    end
                end
                ST_WAIT_CDR: begin
                    if (!i_sigdet) begin
                        state_d = ST_WAIT_SIGDET;
                    end else if (i_cdr_align) begin
                        state_d = ST_PCS_WAIT;
                    end
                end
                ST_PCS_WAIT: begin
                    if (!link_ok) begin
                        state_d = ST_WAIT_SIGDET;
                    end else if (wait_cnt == PCS_WAIT_LAST) begin
                        state_d = ST_WAIT_LSM;
                    end
                end
                ST_WAIT_LSM: begin
                    if (!link_ok) begin
                        state_d = ST_WAIT_SIGDET;
                    end else if (i_word_align) begin
                        state_d = ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (!link_ok) begin
                        state_d = ST_WAIT_SIGDET;
                    end else if (!i_word_align) begin
                        state_d = ST_WAIT_LSM;                // Realign without touching the PMA
                    end
                end
                default: begin
                    state_d = ST_LANE_OFF;
                end
            endcase
        end
    end

    //////////////////////////////
    // State, wait counter and outputs
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!i_lane_rstn) begin
            state_q       <= ST_LANE_OFF;
            wait_cnt      <= '0;
            o_lane_pd     <= 1'b1;
            o_lane_rst    <= 1'b1;
            o_rx_pma_rst  <= 1'b1;
            o_pcs_rx_rst  <= 1'b1;
            o_rxlane_done <= 1'b0;
        end else begin
            state_q <= state_d;

            if (state_d != state_q) begin
                wait_cnt <= '0;                               // Each wait state counts from zero
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end

            // Outputs follow the state being entered so they line up with state_q
            o_lane_pd     <= (state_d == ST_LANE_OFF);
            o_lane_rst    <= (state_d == ST_LANE_OFF) || (state_d == ST_PD_WAIT);
            o_rx_pma_rst  <= (state_d == ST_LANE_OFF) || (state_d == ST_PD_WAIT);
            o_pcs_rx_rst  <= (state_d != ST_WAIT_LSM) && (state_d != ST_DONE);
            o_rxlane_done <= (state_d == ST_DONE);
        end
    end

endmodule

/* design/rx_rise_debounce.sv */
//////////////////////////////
// Rising-edge debounce for one status bit
// The falling edge passes after a single cycle
//////////////////////////////
module rx_rise_debounce #(
    parameter int unsigned RISE_CYCLES = 4
) (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_sig,
    output logic o_sig_deb
);
    import rx_rst_pkg::*;

    localparam logic [DEB_CNT_W-1:0] CNT_LAST = DEB_CNT_W'(RISE_CYCLES - 1);

    logic [DEB_CNT_W-1:0] high_cnt;                           // Consecutive high cycles seen

    // The count stops at its last value and the output is then held high
    // for as long as the input stays high
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            high_cnt  <= '0;
            o_sig_deb <= 1'b0;
        end else if (!i_sig) begin
            high_cnt  <= '0;                                  // Any low cycle restarts the filter
            o_sig_deb <= 1'b0;
        end else if (high_cnt != CNT_LAST) begin
            high_cnt  <= high_cnt + 1'b1;
        end else begin
            o_sig_deb <= 1'b1;                                // Input held long enough
        end
    end

endmodule

/* design/rx_rst_pkg.sv */
//////////////////////////////
// Shared constants and types of the receive reset sequencer
// Lane count, PLL map, debounce and wait lengths, lane FSM states
//////////////////////////////
package rx_rst_pkg;

    //////////////////////////////
    // Lanes and PLL mapping
    //////////////////////////////
    localparam int NUM_LANES = 4;

    typedef logic [NUM_LANES-1:0] lane_vec_t;                 // Bit n belongs to lane n

    // A set bit selects PLL 1 for that lane, a clear bit PLL 0
    localparam lane_vec_t LANE_PLL_SEL = 4'b1100;             // Lanes 2 and 3 run from PLL 1

    //////////////////////////////
    // Input conditioning
    //////////////////////////////
    localparam int SYNC_STAGES = 2;                           // Flop depth of every synchroniser

    localparam int DEB_CNT_W           = 12;                  // Debounce counter width
    localparam int SIGDET_DEB_CYCLES   = 4;                   // Signal detect must hold this long
    localparam int CDR_DEB_CYCLES      = 20;                  // CDR ready filter length
    localparam int PLL_LOCK_DEB_CYCLES = 16;                  // PLL lock filter length

    //////////////////////////////
    // Lane sequencing
    //////////////////////////////
    localparam int PD_WAIT_CYCLES      = 8;                   // Power-up settle before PMA release
    localparam int PCS_RST_WAIT_CYCLES = 8;                   // CDR align to PCS reset release

    // Bring-up order of one receive lane
    typedef enum logic [2:0] {
        ST_LANE_OFF    = 3'd0,                                // Powered down and held in reset
        ST_PD_WAIT     = 3'd1,                                // Powered up and settling
        ST_WAIT_SIGDET = 3'd2,                                // PMA running and waiting for a signal
        ST_WAIT_CDR    = 3'd3,                                // Waiting for the CDR to lock on data
        ST_PCS_WAIT    = 3'd4,                                // CDR locked with PCS still in reset
        ST_WAIT_LSM    = 3'd5,                                // PCS running and waiting for alignment
        ST_DONE        = 3'd6                                 // Lane is up
    } rx_fsm_state_t;

endpackage

/* design/rx_rst_top.sv */
//////////////////////////////
// Four-lane receive reset sequencer
// Status conditioning feeding one reset FSM per lane
//////////////////////////////
module rx_rst_top (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic [1:0]            i_pll_done,
    input  rx_rst_pkg::lane_vec_t i_rxlane_rst,
    input  rx_rst_pkg::lane_vec_t i_pll_lock_rx,
    input  rx_rst_pkg::lane_vec_t i_rx_sigdet_status,
    input  rx_rst_pkg::lane_vec_t i_rx_ready,
    input  rx_rst_pkg::lane_vec_t i_pcs_lsm_synced,
    input  rx_rst_pkg::lane_vec_t i_force_rxfsm_det,
    input  rx_rst_pkg::lane_vec_t i_force_rxfsm_cdr,
    input  rx_rst_pkg::lane_vec_t i_force_rxfsm_lsm,
    output rx_rst_pkg::lane_vec_t o_lane_pd,
    output rx_rst_pkg::lane_vec_t o_lane_rst,
    output rx_rst_pkg::lane_vec_t o_rx_pma_rst,
    output rx_rst_pkg::lane_vec_t o_pcs_rx_rst,
    output rx_rst_pkg::lane_vec_t o_rxlane_done
);
    import rx_rst_pkg::*;

    lane_vec_t lane_rstn;                                     // Per-lane reset for the FSMs
    lane_vec_t pll_lock;
    lane_vec_t sigdet;
    lane_vec_t cdr_align;
    lane_vec_t word_align;

    rx_status_cond u_cond (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_pll_done         (i_pll_done),
        .i_rxlane_rst       (i_rxlane_rst),
        .i_pll_lock_rx      (i_pll_lock_rx),
        .i_rx_sigdet_status (i_rx_sigdet_status),
        .i_rx_ready         (i_rx_ready),
        .i_pcs_lsm_synced   (i_pcs_lsm_synced),
        .i_force_rxfsm_det  (i_force_rxfsm_det),
        .i_force_rxfsm_cdr  (i_force_rxfsm_cdr),
        .i_force_rxfsm_lsm  (i_force_rxfsm_lsm),
        .o_lane_rstn        (lane_rstn),
        .o_pll_lock         (pll_lock),
        .o_sigdet           (sigdet),
        .o_cdr_align        (cdr_align),
        .o_word_align       (word_align)
    );

    // Lanes sequence independently of each other
    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        rx_lane_rst_fsm u_fsm (
            .clk           (clk),
            .i_lane_rstn   (lane_rstn[n]),
            .i_pll_lock    (pll_lock[n]),
            .i_sigdet      (sigdet[n]),
            .i_cdr_align   (cdr_align[n]),
            .i_word_align  (word_align[n]),
            .o_lane_pd     (o_lane_pd[n]),
            .o_lane_rst    (o_lane_rst[n]),
            .o_rx_pma_rst  (o_rx_pma_rst[n]),
            .o_pcs_rx_rst  (o_pcs_rx_rst[n]),
            .o_rxlane_done (o_rxlane_done[n])
        );
    end

endmodule

/* design/rx_status_cond.sv */
//////////////////////////////
// Receive status conditioning for all lanes
// Lane reset with PLL-done gating, status synchronisers,
// debounce filters and debug force merging
//////////////////////////////
module rx_status_cond (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic [1:0]            i_pll_done,
    input  rx_rst_pkg::lane_vec_t i_rxlane_rst,
    input  rx_rst_pkg::lane_vec_t i_pll_lock_rx,
    input  rx_rst_pkg::lane_vec_t i_rx_sigdet_status,
    input  rx_rst_pkg::lane_vec_t i_rx_ready,
    input  rx_rst_pkg::lane_vec_t i_pcs_lsm_synced,
    input  rx_rst_pkg::lane_vec_t i_force_rxfsm_det,
    input  rx_rst_pkg::lane_vec_t i_force_rxfsm_cdr,
    input  rx_rst_pkg::lane_vec_t i_force_rxfsm_lsm,
    output rx_rst_pkg::lane_vec_t o_lane_rstn,
    output rx_rst_pkg::lane_vec_t o_pll_lock,
    output rx_rst_pkg::lane_vec_t o_sigdet,
    output rx_rst_pkg::lane_vec_t o_cdr_align,
    output rx_rst_pkg::lane_vec_t o_word_align
);
    import rx_rst_pkg::*;

    lane_vec_t lock_sync;                                     // Synchronised status per lane
    lane_vec_t sigdet_sync;
    lane_vec_t cdr_sync;
    lane_vec_t lsm_sync;
    lane_vec_t sigdet_deb;                                    // Debounced status per lane
    lane_vec_t cdr_deb;

    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        logic [SYNC_STAGES-1:0]      rst_chain;               // Carries the released lane request
        logic                        pll_done_sel;
        logic [3:0]                  stat_raw;
        logic [SYNC_STAGES-1:0][3:0] stat_sync;

        //////////////////////////////
        // Lane reset
        //////////////////////////////
        assign pll_done_sel = i_pll_done[LANE_PLL_SEL[n]];

        always_ff @(posedge clk) begin
            if (!i_rst_n) begin
                rst_chain <= '0;
            end else begin
                rst_chain <= {rst_chain[SYNC_STAGES-2:0], ~i_rxlane_rst[n]};
            end
        end

        // The PLL done flag drops the lane at once without going through the chain
        assign o_lane_rstn[n] = rst_chain[SYNC_STAGES-1] & pll_done_sel;

        //////////////////////////////
        // Status synchronisers
        //////////////////////////////
        assign stat_raw = {i_pcs_lsm_synced[n], i_rx_ready[n],
                           i_rx_sigdet_status[n], i_pll_lock_rx[n]};

        always_ff @(posedge clk) begin
            if (!o_lane_rstn[n]) begin
                stat_sync <= '0;                              // Held low while the lane is in reset
            end else begin
                stat_sync <= {stat_sync[SYNC_STAGES-2:0], stat_raw};
            end
        end

        assign {lsm_sync[n], cdr_sync[n], sigdet_sync[n], lock_sync[n]} =
            stat_sync[SYNC_STAGES-1];

        //////////////////////////////
        // Debounce filters
        //////////////////////////////
        rx_rise_debounce #(
            .RISE_CYCLES (PLL_LOCK_DEB_CYCLES)
        ) u_lock_deb (
            .clk       (clk),
            .i_rst_n   (o_lane_rstn[n]),
            .i_sig     (lock_sync[n]),
            .o_sig_deb (o_pll_lock[n])
        );

        rx_rise_debounce #(
            .RISE_CYCLES (SIGDET_DEB_CYCLES)
        ) u_sigdet_deb (
            .clk       (clk),
            .i_rst_n   (o_lane_rstn[n]),
            .i_sig     (sigdet_sync[n]),
            .o_sig_deb (sigdet_deb[n])
        );

        rx_rise_debounce #(
            .RISE_CYCLES (CDR_DEB_CYCLES)
        ) u_cdr_deb (
            .clk       (clk),
            .i_rst_n   (o_lane_rstn[n]),
            .i_sig     (cdr_sync[n]),
            .o_sig_deb (cdr_deb[n])
        );
    end

    // Debug forces stand in for the PMA and PCS status in loopback work
    assign o_sigdet     = sigdet_deb | i_force_rxfsm_det;
    assign o_cdr_align  = cdr_deb    | i_force_rxfsm_cdr;
    assign o_word_align = lsm_sync   | i_force_rxfsm_lsm;  // Word alignment is not debounced

endmodule

/* flist.f */
design/rx_rst_pkg.sv
design/rx_rise_debounce.sv
design/rx_status_cond.sv
design/rx_lane_rst_fsm.sv
design/rx_rst_top.sv
sim/rx_rst_asserts.sv
sim/tb_rx_rst.sv

/* sim/rx_rst_asserts.sv */
//////////////////////////////
// Reset ordering checks bound into each lane FSM
// Done, PCS release and power-down consistency
//////////////////////////////
module rx_rst_asserts (
    input logic clk,
    input logic i_lane_rstn,
    input logic i_lane_pd,
    input logic i_lane_rst,
    input logic i_rx_pma_rst,
    input logic i_pcs_rx_rst,
    input logic i_rxlane_done
);
    int done_fail_cnt = 0;                                    // Failures of each property
    int pcs_fail_cnt  = 0;
    int pd_fail_cnt   = 0;
    int fail_total;

    assign fail_total = done_fail_cnt + pcs_fail_cnt + pd_fail_cnt;

    done_clean: assert property (@(posedge clk) disable iff (!i_lane_rstn)
        i_rxlane_done |-> !(i_lane_pd | i_lane_rst | i_rx_pma_rst | i_pcs_rx_rst))
        else begin
            $error("Lane done while a reset or power-down output is still active");
            done_fail_cnt++;
        end

    pcs_after_pma: assert property (@(posedge clk) disable iff (!i_lane_rstn)
        !i_pcs_rx_rst |-> !i_rx_pma_rst)
        else begin
            $error("PCS reset released while the PMA reset is still held");
            pcs_fail_cnt++;
        end

    pd_not_done: assert property (@(posedge clk) disable iff (!i_lane_rstn)
        i_lane_pd |-> !i_rxlane_done)
        else begin
            $error("Lane powered down while reporting done");
            pd_fail_cnt++;
        end

endmodule

bind rx_lane_rst_fsm rx_rst_asserts u_asserts (
    .clk           (clk),
    .i_lane_rstn   (i_lane_rstn),
    .i_lane_pd     (o_lane_pd),
    .i_lane_rst    (o_lane_rst),
    .i_rx_pma_rst  (o_rx_pma_rst),
    .i_pcs_rx_rst  (o_pcs_rx_rst),
    .i_rxlane_done (o_rxlane_done)
);

/* sim/rx_rst_golden.txt */
// hold pll_done rxlane_rst pll_lock sigdet ready lsm frc_det frc_cdr frc_lsm (hex, bit n = lane n)
// then expected lane_pd lane_rst rx_pma_rst pcs_rx_rst rxlane_done; hold is in cycles (hex)
// Reset state with every status input low
40 3 0 0 0 0 0 0 0 0  f f f f 0
// Full bring-up of all lanes
50 3 0 f f f f 0 0 0  0 0 0 0 f
// Signal detect lost on lane 1, then restored
40 3 0 f d f f 0 0 0  0 0 0 2 d
50 3 0 f f f f 0 0 0  0 0 0 0 f
// PLL 1 done cleared drops lanes 2 and 3
40 1 0 f f f f 0 0 0  c c c c 3
50 3 0 f f f f 0 0 0  0 0 0 0 f
// Lane reset request on lane 0
40 3 1 f f f f 0 0 0  1 1 1 1 e
50 3 0 f f f f 0 0 0  0 0 0 0 f
// Lane 3 status lost, then forced, then forced through a lane reset
40 3 0 f 7 7 7 0 0 0  0 0 0 8 7
50 3 0 f 7 7 7 8 8 8  0 0 0 0 f
40 3 8 f 7 7 7 8 8 8  8 8 8 8 7
50 3 0 f 7 7 7 8 8 8  0 0 0 0 f
// PLL lock lost on lane 2, then regained
40 3 0 b 7 7 7 8 8 8  4 4 4 4 b
50 3 0 f 7 7 7 8 8 8  0 0 0 0 f

/* sim/tb_rx_rst.sv */
//////////////////////////////
// Testbench for the receive reset sequencer
// Steps and expected outputs come from the golden file
//////////////////////////////
module tb_rx_rst;
    import rx_rst_pkg::*;

    localparam int    FIELDS         = 15;                    // Words per golden line
    localparam int    MAX_STEPS      = 32;
    localparam int    CLK_HALF       = 4;
    localparam int    DRIVE_DELAY    = 1;
    localparam int    RESET_CYCLES   = 10;
    localparam int    TIMEOUT_MARGIN = 200;
    localparam string GOLDEN_FILE    = "sim/rx_rst_golden.txt";

    logic       clk;
    logic       i_rst_n;
    logic [1:0] i_pll_done;
    lane_vec_t  i_rxlane_rst;
    lane_vec_t  i_pll_lock_rx;
    lane_vec_t  i_rx_sigdet_status;
    lane_vec_t  i_rx_ready;
    lane_vec_t  i_pcs_lsm_synced;
    lane_vec_t  i_force_rxfsm_det;
    lane_vec_t  i_force_rxfsm_cdr;
    lane_vec_t  i_force_rxfsm_lsm;
    lane_vec_t  o_lane_pd;
    lane_vec_t  o_lane_rst;
    lane_vec_t  o_rx_pma_rst;
    lane_vec_t  o_pcs_rx_rst;
    lane_vec_t  o_rxlane_done;

    logic [15:0] golden_mem [0:MAX_STEPS*FIELDS-1];
    int          num_steps;
    int          total_hold;
    int          timeout_limit;
    bit          timeout_armed = 1'b0;
    int          step_errors;                                 // Mismatches in the running step
    int          steps_passed = 0;
    int          steps_failed = 0;
    int          assert_fails;

    rx_rst_top i_dut (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_pll_done         (i_pll_done),
        .i_rxlane_rst       (i_rxlane_rst),
        .i_pll_lock_rx      (i_pll_lock_rx),
        .i_rx_sigdet_status (i_rx_sigdet_status),
        .i_rx_ready         (i_rx_ready),
        .i_pcs_lsm_synced   (i_pcs_lsm_synced),
        .i_force_rxfsm_det  (i_force_rxfsm_det),
        .i_force_rxfsm_cdr  (i_force_rxfsm_cdr),
        .i_force_rxfsm_lsm  (i_force_rxfsm_lsm),
        .o_lane_pd          (o_lane_pd),
        .o_lane_rst         (o_lane_rst),
        .o_rx_pma_rst       (o_rx_pma_rst),
        .o_pcs_rx_rst       (o_pcs_rx_rst),
        .o_rxlane_done      (o_rxlane_done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Watchdog sized from the hold counts of the golden file
    initial begin : watchdog
        int cycles;
        wait (timeout_armed);
        for (cycles = 0; cycles < timeout_limit; cycles++) begin
            @(posedge clk);
        end
        $display("Timeout: the steps did not finish within %0d cycles", timeout_limit);
        $display("Done: errors found");
        $finish;
    end

    function automatic bit step_present(input int idx);
        return !$isunknown(golden_mem[idx*FIELDS]) && (golden_mem[idx*FIELDS] != 16'h0);
    endfunction

    task automatic check_value(input string name, input logic [3:0] actual,
                               input logic [3:0] expected);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s = %h, expected %h", $time, name, actual, expected);
            step_errors++;
        end
    endtask

    task automatic drive_step(input int idx);
        int base;
        base               = idx * FIELDS;
        i_pll_done         = golden_mem[base+1][1:0];
        i_rxlane_rst       = golden_mem[base+2][3:0];
        i_pll_lock_rx      = golden_mem[base+3][3:0];
        i_rx_sigdet_status = golden_mem[base+4][3:0];
        i_rx_ready         = golden_mem[base+5][3:0];
        i_pcs_lsm_synced   = golden_mem[base+6][3:0];
        i_force_rxfsm_det  = golden_mem[base+7][3:0];
        i_force_rxfsm_cdr  = golden_mem[base+8][3:0];
        i_force_rxfsm_lsm  = golden_mem[base+9][3:0];
    endtask

    task automatic check_step(input int idx);
        int base;
        base = idx * FIELDS;
        check_value("o_lane_pd",     o_lane_pd,     golden_mem[base+10][3:0]);
        check_value("o_lane_rst",    o_lane_rst,    golden_mem[base+11][3:0]);
        check_value("o_rx_pma_rst",  o_rx_pma_rst,  golden_mem[base+12][3:0]);
        check_value("o_pcs_rx_rst",  o_pcs_rx_rst,  golden_mem[base+13][3:0]);
        check_value("o_rxlane_done", o_rxlane_done, golden_mem[base+14][3:0]);
    endtask

    initial begin : main
        int step;
        int hold;
        i_rst_n    = 1'b0;
        {i_rxlane_rst, i_pll_lock_rx, i_rx_sigdet_status, i_rx_ready} = '0;
        {i_pcs_lsm_synced, i_force_rxfsm_det, i_force_rxfsm_cdr, i_force_rxfsm_lsm} = '0;
        i_pll_done = 2'b00;

        $readmemh(GOLDEN_FILE, golden_mem);
        num_steps  = 0;
        total_hold = 0;
        while (num_steps < MAX_STEPS && step_present(num_steps)) begin
            total_hold += int'(golden_mem[num_steps*FIELDS]);
            num_steps++;
        end
        timeout_limit = total_hold + TIMEOUT_MARGIN;
        timeout_armed = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        i_rst_n = 1'b1;

        for (step = 0; step < num_steps; step++) begin
            drive_step(step);
            hold = int'(golden_mem[step*FIELDS]);
            repeat (hold) @(posedge clk);
            #DRIVE_DELAY;                                     // Outputs are settled after the edge
            step_errors = 0;
            check_step(step);
            if (step_errors == 0) begin
                steps_passed++;
                $display("Step %0d after %0d cycles: pass", step + 1, hold);
            end else begin
                steps_failed++;
                $display("Step %0d after %0d cycles: FAIL with %0d mismatches",
                         step + 1, hold, step_errors);
            end
        end

        assert_fails = i_dut.g_lane[0].u_fsm.u_asserts.fail_total
                     + i_dut.g_lane[1].u_fsm.u_asserts.fail_total
                     + i_dut.g_lane[2].u_fsm.u_asserts.fail_total
                     + i_dut.g_lane[3].u_fsm.u_asserts.fail_total;
        if (num_steps == 0) begin
            $display("The golden file supplied no stimulus steps");
        end
        $display("Steps run %0d, passed %0d, failed %0d, assertion failures %0d",
                 num_steps, steps_passed, steps_failed, assert_fails);
        if (num_steps > 0 && steps_failed == 0 && assert_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
